// ==== include/cpu_consts.svh ====
// cpu constants: reset vector, queue sizing and MIPS32 opcode/funct encodings
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define RESET_PC    32'hbfc0_0000   // boot rom entry
`define QUEUE_DEPTH 4               // queue slots and initial credits, 1..8
`define CRED_W      4               // holds up to 8 credits

// primary opcodes
`define OP_SPECIAL  6'h00
`define OP_ADDIU    6'h09
`define OP_ANDI     6'h0c
`define OP_ORI      6'h0d
`define OP_XORI     6'h0e
`define OP_LUI      6'h0f

// special funct codes
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_NOR      6'h27
`define FN_SLT      6'h2a
`define FN_SLTU     6'h2b

`endif

// ==== logic/cpu_pkg.sv ====
// cpu package: queue entry, alu operation and decoded instruction types with the decoder
`include "cpu_consts.svh"

package cpu_pkg;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } inst_entry_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU, ALU_LUI
    } alu_op_e;

    typedef struct packed {
        alu_op_e     alu_op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
        logic        use_imm;
        logic [31:0] imm32;   // already extended
        logic        reg_wr;
    } decoded_t;

    // anything outside the supported subset comes back with reg_wr low
    function automatic decoded_t decode_instr(input logic [31:0] instr);
        decoded_t   d;
        logic [5:0] op;
        logic [5:0] fn;
        op        = instr[31:26];
        fn        = instr[5:0];
        d.alu_op  = ALU_ADD;
        d.rs      = instr[25:21];
        d.rt      = instr[20:16];
        d.use_imm = (op != `OP_SPECIAL);                        // every i-type takes an imm
        d.dst     = d.use_imm ? instr[20:16] : instr[15:11];
        d.imm32   = (op == `OP_ADDIU) ? {{16{instr[15]}}, instr[15:0]}
                                      : {16'h0000, instr[15:0]};
        d.reg_wr  = 1'b1;
        case (op)
            `OP_SPECIAL: begin
                case (fn)
                    `FN_ADDU: d.alu_op = ALU_ADD;
                    `FN_SUBU: d.alu_op = ALU_SUB;
                    `FN_AND:  d.alu_op = ALU_AND;
                    `FN_OR:   d.alu_op = ALU_OR;
                    `FN_XOR:  d.alu_op = ALU_XOR;
                    `FN_NOR:  d.alu_op = ALU_NOR;
                    `FN_SLT:  d.alu_op = ALU_SLT;
                    `FN_SLTU: d.alu_op = ALU_SLTU;
                    default:  d.reg_wr = 1'b0;                  // sll nop lands here too
                endcase
            end
            `OP_ADDIU: d.alu_op = ALU_ADD;
            `OP_ANDI:  d.alu_op = ALU_AND;
            `OP_ORI:   d.alu_op = ALU_OR;
            `OP_XORI:  d.alu_op = ALU_XOR;
            `OP_LUI:   d.alu_op = ALU_LUI;
            default:   d.reg_wr = 1'b0;
        endcase
        return d;
    endfunction

endpackage

// ==== logic/fetch_queue_if.sv ====
// fetch/queue/execute link: queue entries forward, credits back to fetch
interface fetch_queue_if import cpu_pkg::*; ();

    logic        push;         // one per sram response
    inst_entry_t push_entry;
    logic        pop;          // execute consumes the head
    logic        head_valid;
    inst_entry_t head_entry;
    logic        credit_ret;   // one slot freed

    modport fetch_mp (
        output push,
        output push_entry,
        input  credit_ret
    );

    modport queue_mp (
        input  push,
        input  push_entry,
        input  pop,
        output head_valid,
        output head_entry
    );

    modport exec_mp (
        input  head_valid,
        input  head_entry,
        output pop,
        output credit_ret
    );

endinterface

// ==== logic/inst_fetch.sv ====
// instruction fetch: pc and credit counter, sram request and response capture into the queue
`include "cpu_consts.svh"

module inst_fetch (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic [31:0]              inst_sram_rdata_i,
    output logic                     inst_sram_en_o,
    output logic [31:0]              inst_sram_addr_o,
    fetch_queue_if.fetch_mp          fq
);

    logic [31:0]         pc_q;
    logic [`CRED_W-1:0]  credits_q;
    logic [`CRED_W-1:0]  cred_next;
    logic                fetch_en_q;   // registered request strobe
    logic                req_q;        // response due this cycle
    logic [31:0]         req_pc_q;

    // spend on request, regain on pop, both may happen in one cycle
    always_comb begin
        cred_next = credits_q;
        if (fetch_en_q && !fq.credit_ret) begin
            cred_next = credits_q - 1'b1;
        end else if (!fetch_en_q && fq.credit_ret) begin
            cred_next = credits_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q       <= `RESET_PC;
            credits_q  <= `CRED_W'(`QUEUE_DEPTH);
            fetch_en_q <= 1'b0;
            req_q      <= 1'b0;
        end else begin
            credits_q  <= cred_next;
            fetch_en_q <= (cred_next != '0);   // request next cycle only with a credit left
            req_q      <= fetch_en_q;
            if (fetch_en_q) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    // pc of the word the sram is returning
    always_ff @(posedge clk) begin
        if (fetch_en_q) begin
            req_pc_q <= pc_q;
        end
    end

    assign inst_sram_en_o   = fetch_en_q;
    assign inst_sram_addr_o = pc_q;       // held while out of credits

    assign fq.push             = req_q;
    assign fq.push_entry.pc    = req_pc_q;
    assign fq.push_entry.instr = inst_sram_rdata_i;

    // execute must never hand back more credits than fetch spent
    a_credit_bound: assert property (
        @(posedge clk) disable iff (reset_i) credits_q <= `CRED_W'(`QUEUE_DEPTH)
    ) else $error("credit count above queue depth");

endmodule

// ==== logic/inst_queue.sv ====
// instruction queue: circular fifo of fetched entries with the head shown combinationally
`include "cpu_consts.svh"

module inst_queue import cpu_pkg::*; (
    input  logic             clk,
    input  logic             reset_i,
    fetch_queue_if.queue_mp  fq
);

    localparam int DEPTH = `QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    inst_entry_t      mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;

    assign full = (count_q == CNT_W'(DEPTH));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (fq.push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (fq.pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({fq.push, fq.pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fq.push) begin
            mem_q[wr_ptr_q] <= fq.push_entry;
        end
    end

    assign fq.head_valid = (count_q != '0);
    assign fq.head_entry = mem_q[rd_ptr_q];

    // credits upstream are supposed to make overflow impossible
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset_i) !(fq.push && full)
    ) else $error("push into full instruction queue");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset_i) !(fq.pop && !fq.head_valid)
    ) else $error("pop from empty instruction queue");

endmodule

// ==== logic/exec_unit.sv ====
// execute unit: decode, register file, alu and write-back with debug retire ports
module exec_unit import cpu_pkg::*; (
    input  logic             clk,
    input  logic             reset_i,
    fetch_queue_if.exec_mp   fq,
    output logic             debug_wb_valid_o,
    output logic [31:0]      debug_wb_pc_o,
    output logic [3:0]       debug_wb_rf_wen_o,
    output logic [4:0]       debug_wb_rf_wnum_o,
    output logic [31:0]      debug_wb_rf_wdata_o
);

    decoded_t    dec;
    logic [31:0] rf_q [32];
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic        wr_en;

    assign dec = decode_instr(fq.head_entry.instr);

    // r0 reads as zero whatever the array holds
    assign rs_val = (dec.rs == 5'd0) ? 32'h0 : rf_q[dec.rs];
    assign rt_val = (dec.rt == 5'd0) ? 32'h0 : rf_q[dec.rt];
    assign op_b   = dec.use_imm ? dec.imm32 : rt_val;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_res = rs_val + op_b;
            ALU_SUB:  alu_res = rs_val - op_b;
            ALU_AND:  alu_res = rs_val & op_b;
            ALU_OR:   alu_res = rs_val | op_b;
            ALU_XOR:  alu_res = rs_val ^ op_b;
            ALU_NOR:  alu_res = ~(rs_val | op_b);
            ALU_SLT:  alu_res = {31'h0, $signed(rs_val) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'h0, rs_val < op_b};
            ALU_LUI:  alu_res = {op_b[15:0], 16'h0000};
            default:  alu_res = 32'h0;
        endcase
    end

    assign wr_en = dec.reg_wr && (dec.dst != 5'd0);   // writes to r0 dropped

    // single in-order stage, so the head is always consumed at once
    assign fq.pop        = fq.head_valid;
    assign fq.credit_ret = fq.head_valid;   // slot freed by this pop

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rf_q <= '{default: 32'h0};
        end else if (fq.pop && wr_en) begin
            rf_q[dec.dst] <= alu_res;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            debug_wb_valid_o  <= 1'b0;
            debug_wb_rf_wen_o <= 4'b0000;
        end else begin
            debug_wb_valid_o  <= fq.pop;
            debug_wb_rf_wen_o <= (fq.pop && wr_en) ? 4'b1111 : 4'b0000;
        end
    end

    // retire payload, qualified by debug_wb_valid_o
    always_ff @(posedge clk) begin
        if (fq.pop) begin
            debug_wb_pc_o       <= fq.head_entry.pc;
            debug_wb_rf_wnum_o  <= dec.dst;
            debug_wb_rf_wdata_o <= alu_res;
        end
    end

    // back-to-back pops see the sequential stream with no gap or repeat
    a_pc_in_order: assert property (
        @(posedge clk) disable iff (reset_i)
        (fq.pop && debug_wb_valid_o) |-> fq.head_entry.pc == debug_wb_pc_o + 32'd4
    ) else $error("queue head pc does not follow the last retired pc");

endmodule

// ==== logic/mycpu_top.sv ====
// mycpu top: fetch, instruction queue and execute between the instruction sram and debug ports
module mycpu_top (
    input  logic        clk,
    input  logic        reset_i,
    input  logic [31:0] inst_sram_rdata_i,
    output logic        inst_sram_en_o,
    output logic [31:0] inst_sram_addr_o,
    output logic        debug_wb_valid_o,
    output logic [31:0] debug_wb_pc_o,
    output logic [3:0]  debug_wb_rf_wen_o,
    output logic [4:0]  debug_wb_rf_wnum_o,
    output logic [31:0] debug_wb_rf_wdata_o
);

    fetch_queue_if fq ();

    inst_fetch u_fetch (
        .clk               (clk),
        .reset_i           (reset_i),
        .inst_sram_rdata_i (inst_sram_rdata_i),
        .inst_sram_en_o    (inst_sram_en_o),
        .inst_sram_addr_o  (inst_sram_addr_o),
        .fq                (fq.fetch_mp)
    );

    inst_queue u_queue (
        .clk     (clk),
        .reset_i (reset_i),
        .fq      (fq.queue_mp)
    );

    exec_unit u_exec (
        .clk                 (clk),
        .reset_i             (reset_i),
        .fq                  (fq.exec_mp),
        .debug_wb_valid_o    (debug_wb_valid_o),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

endmodule

// ==== sim/tb_mycpu.sv ====
// mycpu testbench with instruction sram model, isa reference model and retire checker
`include "cpu_consts.svh"

module tb_mycpu;

    localparam int MEM_WORDS = 64;
    localparam int TIMEOUT   = 400;    // cycles per test

    typedef struct packed {
        logic [31:0] pc;
        logic [3:0]  wen;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } retire_t;

    logic        clk = 1'b0;
    logic        reset_i;
    logic [31:0] inst_sram_rdata_i;
    logic        inst_sram_en_o;
    logic [31:0] inst_sram_addr_o;
    logic        debug_wb_valid_o;
    logic [31:0] debug_wb_pc_o;
    logic [3:0]  debug_wb_rf_wen_o;
    logic [4:0]  debug_wb_rf_wnum_o;
    logic [31:0] debug_wb_rf_wdata_o;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] prog [$];
    logic [31:0] model_rf [32];
    logic [31:0] model_pc;
    logic [31:0] fetch_pc;             // next expected request address
    logic [31:0] rng = 32'd47;
    logic [5:0]  rfn [8] = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR,
                             `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU};
    logic [5:0]  iop [5] = '{`OP_ADDIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI};
    int          prog_len = 0;
    int          fetched = 0;
    int          retired = 0;
    int          rst_cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          failed_tests = 0;
    bit          timed_out = 1'b0;

    mycpu_top dut0 (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `RESET_PC) >> 2;
        return (idx < MEM_WORDS) ? mem[idx] : 32'h0;   // nop past the program
    endfunction

    function automatic logic [31:0] rtype(input int rs, input int rt, input int rd,
                                          input logic [5:0] fn);
        return {`OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // one retirement of the isa model, model_rf[0] is never written
    function automatic retire_t ref_step(input logic [31:0] instr);
        retire_t     r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] zimm;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        ok;
        a    = model_rf[instr[25:21]];
        b    = model_rf[instr[20:16]];
        zimm = {16'h0000, instr[15:0]};
        dst  = instr[20:16];
        ok   = 1'b1;
        res  = 32'h0;
        case (instr[31:26])
            `OP_SPECIAL: begin
                dst = instr[15:11];
                case (instr[5:0])
                    `FN_ADDU: res = a + b;
                    `FN_SUBU: res = a - b;
                    `FN_AND:  res = a & b;
                    `FN_OR:   res = a | b;
                    `FN_XOR:  res = a ^ b;
                    `FN_NOR:  res = ~(a | b);
                    `FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    default:  ok  = 1'b0;
                endcase
            end
            `OP_ADDIU: res = a + {{16{instr[15]}}, instr[15:0]};   // sign extended
            `OP_ANDI:  res = a & zimm;
            `OP_ORI:   res = a | zimm;
            `OP_XORI:  res = a ^ zimm;
            `OP_LUI:   res = zimm << 16;
            default:   ok  = 1'b0;
        endcase
        r.pc    = model_pc;
        r.wen   = (ok && dst != 5'd0) ? 4'hf : 4'h0;
        r.wnum  = dst;
        r.wdata = res;
        if (r.wen != 4'h0) begin
            model_rf[dst] = res;
        end
        model_pc = model_pc + 32'd4;
        return r;
    endfunction

    // sram answers one cycle after the request
    always @(posedge clk) begin
        if (inst_sram_en_o) begin
            inst_sram_rdata_i <= mem_word(inst_sram_addr_o);
        end
    end

    always @(posedge clk) begin
        retire_t want;
        if (reset_i) begin
            rst_cycles++;
            if (rst_cycles >= 2 && (inst_sram_en_o || debug_wb_valid_o)) begin
                errors++;
                $display("[FAIL] %0t: sram enable or retire valid high in reset", $time);
            end
            fetch_pc = `RESET_PC;
            model_pc = `RESET_PC;
            model_rf = '{default: 32'h0};
            fetched  = 0;
            retired  = 0;
        end else begin
            rst_cycles = 0;
            if (inst_sram_en_o) begin
                if (inst_sram_addr_o != fetch_pc) begin
                    errors++;
                    $display("[FAIL] %0t: fetch address %h, expected %h",
                             $time, inst_sram_addr_o, fetch_pc);
                end
                if (fetch_pc - `RESET_PC < 32'(4 * prog_len)) begin
                    fetched++;
                end
                fetch_pc = fetch_pc + 32'd4;
            end
            if (debug_wb_valid_o) begin
                want = ref_step(mem_word(model_pc));
                checks++;
                if (debug_wb_pc_o != want.pc || debug_wb_rf_wen_o != want.wen) begin
                    errors++;
                    $display("[FAIL] %0t: retire pc %h wen %h, expected pc %h wen %h", $time,
                             debug_wb_pc_o, debug_wb_rf_wen_o, want.pc, want.wen);
                end else if (want.wen != 4'h0 && (debug_wb_rf_wnum_o != want.wnum ||
                                                  debug_wb_rf_wdata_o != want.wdata)) begin
                    errors++;
                    $display("[FAIL] %0t: pc %h wrote r%0d=%h, expected r%0d=%h", $time,
                             debug_wb_pc_o, debug_wb_rf_wnum_o, debug_wb_rf_wdata_o,
                             want.wnum, want.wdata);
                end
                if (want.pc - `RESET_PC < 32'(4 * prog_len)) begin
                    retired++;
                end
            end
        end
    end

    // lui/ori pairs fill r1..r8
    task automatic load_regs();
        logic [31:0] v;
        for (int r = 1; r <= 8; r++) begin
            v = xorshift32();
            prog.push_back(itype(`OP_LUI, 0, r, v[31:16]));
            prog.push_back(itype(`OP_ORI, r, r, v[15:0]));
        end
    endtask

    task automatic run_test(input string name);
        int err0;
        int cycles;
        err0   = errors;
        cycles = 0;
        if (!timed_out) begin
            tests_run++;
            @(posedge clk);
            reset_i <= 1'b1;
            repeat (3) @(posedge clk);
            foreach (mem[i]) begin
                mem[i] = (i < prog.size()) ? prog[i] : 32'h0;
            end
            prog_len = prog.size();
            repeat (5) @(posedge clk);
            reset_i <= 1'b0;
            @(negedge clk);
            while (retired < prog_len && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (retired < prog_len) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout in %s, only %0d of %0d instructions retired",
                         name, retired, prog_len);
            end else if (fetched != retired) begin
                errors++;
                $display("[FAIL] %0t: %s fetched %0d program words but retired %0d",
                         $time, name, fetched, retired);
            end
            if (errors != err0) begin
                failed_tests++;
            end
            $display("test %-12s %s", name, (errors == err0) ? "passed" : "failed");
        end
        prog.delete();
    endtask

    initial begin
        logic [31:0] w;
        int          prev;
        int          dst;
        reset_i           = 1'b1;
        inst_sram_rdata_i = 32'h0;
        for (int i = 0; i < 6; i++) begin
            prog.push_back(itype(`OP_ADDIU, i, i + 1, 16'(xorshift32())));
        end
        run_test("reset_fetch");
        load_regs();
        for (int i = 0; i < 24; i++) begin
            w = xorshift32();
            prog.push_back(rtype(w[2:0] + 1, w[5:3] + 1, w[9:6] + 1, rfn[w[12:10]]));
        end
        run_test("rtype");
        load_regs();
        for (int i = 0; i < 24; i++) begin
            w = xorshift32();
            prog.push_back(itype(iop[w % 5], w[2:0], w[5:3] + 1,
                                 w[31:16] | (i[0] ? 16'h8000 : 16'h0000)));   // odd ones negative
        end
        run_test("imm_ext");
        load_regs();
        prev = 1;
        for (int i = 0; i < 20; i++) begin
            w   = xorshift32();
            dst = 9 + i % 7;
            if (i[0]) begin
                prog.push_back(itype(iop[w % 4], prev, dst, w[31:16]));
            end else begin
                prog.push_back(rtype(prev, w[2:0] + 1, dst, rfn[w[5:3]]));
            end
            prev = dst;
        end
        run_test("dep_chain");
        load_regs();
        w = xorshift32();
        prog.push_back(itype(`OP_ADDIU, 1, 0, 16'h8001));
        prog.push_back(rtype(1, 2, 0, `FN_ADDU));
        prog.push_back(itype(`OP_LUI, 0, 0, 16'hffff));
        prog.push_back({6'h23, w[25:0]});            // lw
        prog.push_back(rtype(1, 2, 3, 6'h08));       // jr funct
        prog.push_back({6'h00, w[25:6], 6'h00});     // sll
        prog.push_back(rtype(0, 0, 9, `FN_ADDU));
        prog.push_back(rtype(0, 1, 10, `FN_OR));
        prog.push_back(itype(`OP_ORI, 0, 11, 16'h5a5a));
        prog.push_back(itype(`OP_ADDIU, 0, 12, 16'hffff));
        run_test("r0_unsup");
        $display("summary %0d tests run, %0d failed, %0d retirements checked, %0d errors",
                 tests_run, failed_tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
logic/cpu_pkg.sv
logic/fetch_queue_if.sv
logic/inst_fetch.sv
logic/inst_queue.sv
logic/exec_unit.sv
logic/mycpu_top.sv
sim/tb_mycpu.sv

// ==== Bender.yml ====
package:
  name: mycpu

export_include_dirs:
  - include

sources:
  - files:
      - logic/cpu_pkg.sv
      - logic/fetch_queue_if.sv
      - logic/inst_fetch.sv
      - logic/inst_queue.sv
      - logic/exec_unit.sv
      - logic/mycpu_top.sv
  - target: simulation
    files:
      - sim/tb_mycpu.sv
